// File: filelist.f
+incdir+design
design/nn_pkg.sv
design/nn_lane_if.sv
design/nn_preprocess.sv
design/nn_neuron.sv
design/nn_output_layer.sv
design/nn_top.sv
verification/nn_tb.sv

// File: Makefile
# Verilator build and run of the accelerator testbench
# make        build and run, exit status is the test result
# make lint   lint only
# make clean  remove build output

VERILATOR  ?= verilator
TOP        ?= nn_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert -Wall

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) design/nn_cfg.svh

.PHONY: all run lint clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verification/nn_tb.sv
//==========================================================================
// Testbench of the accelerator top level
// Clock, reset, stimulus, reference model, scoreboard queue, assertions
//==========================================================================
`default_nettype none

`include "nn_cfg.svh"

module nn_tb import nn_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DRAIN_LIMIT = 50;        // Cycles allowed for the last results

    // Expected result, field order matches the output concatenation
    typedef struct packed {
        nn_data_t  data;
        logic      ovf;
        logic      zero;
        nn_stage_t ovf_stage;
        nn_stage_t zero_stage;
    } result_t;

    logic      clk = 1'b0;
    logic      resetn;
    logic      enable;
    nn_data_t  input_1;
    nn_data_t  input_2;
    logic      out_valid;
    nn_data_t  final_output;
    logic      total_ovf;
    logic      total_zero;
    nn_stage_t ovf_stage;
    nn_stage_t zero_stage;

    result_t   exp_q [$];                   // Items in flight, oldest first

    nn_top i_dut (
        .clk          (clk),
        .resetn       (resetn),
        .enable       (enable),
        .input_1      (input_1),
        .input_2      (input_2),
        .out_valid    (out_valid),
        .final_output (final_output),
        .total_ovf    (total_ovf),
        .total_zero   (total_zero),
        .ovf_stage    (ovf_stage),
        .zero_stage   (zero_stage)
    );

    always #10 clk = ~clk;                  // 20 ns period

    //==========================================================================
    // Helpers and reference model
    //==========================================================================
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    // Value fits one signed data word
    function automatic bit fits(input longint v);
        return (v >= -(64'sd1 <<< (`NN_DATA_W-1))) && (v < (64'sd1 <<< (`NN_DATA_W-1)));
    endfunction

    // Low word, as the hardware keeps it
    function automatic nn_data_t wrap(input longint v);
        return nn_data_t'(v[`NN_DATA_W-1:0]);
    endfunction

    function automatic bit at_reset_values();
        return !out_valid && final_output == '0 && !total_ovf && !total_zero &&
               ovf_stage == `NN_STAGE_NONE && zero_stage == `NN_STAGE_NONE;
    endfunction

    // One result as text for error lines
    function automatic string result_text(input result_t r);
        return $sformatf("%0d ovf %0b/%0d zero %0b/%0d", r.data, r.ovf, r.ovf_stage,
                         r.zero, r.zero_stage);
    endfunction

    function automatic result_t model(input nn_data_t a, input nn_data_t b);
        result_t  r;
        nn_data_t s0, s1, h0, h1;
        longint   m0, m1, v;
        logic     ovf0, ovf1, hit, zhit;
        // Input shift, zero in either input marks the item
        s0           = a >>> `NN_PRE_SHIFT_0;
        s1           = b >>> `NN_PRE_SHIFT_1;
        r.ovf        = 1'b0;
        r.ovf_stage  = `NN_STAGE_NONE;
        r.zero       = (s0 == '0) || (s1 == '0);
        r.zero_stage = r.zero ? `NN_STAGE_PRE : `NN_STAGE_NONE;
        // Hidden neurons, exact products against the word range
        m0   = longint'(s0) * longint'(`NN_W0);
        m1   = longint'(s1) * longint'(`NN_W1);
        h0   = wrap(m0 + `NN_B0);
        h1   = wrap(m1 + `NN_B1);
        ovf0 = !fits(m0) || !fits(m0 + `NN_B0);
        ovf1 = !fits(m1) || !fits(m1 + `NN_B1);
        zhit = (!ovf0 && h0 == '0) || (!ovf1 && h1 == '0);  // Lane-local check
        if (ovf0 || ovf1) begin
            r.ovf       = 1'b1;
            r.ovf_stage = `NN_STAGE_HID;
        end
        if (zhit && r.zero_stage == `NN_STAGE_NONE) r.zero_stage = `NN_STAGE_HID;
        r.zero |= zhit;
        // Output neuron
        m0  = longint'(h0) * `NN_WO0;
        m1  = longint'(h1) * `NN_WO1;
        v   = m0 + m1 + `NN_BO;
        hit = !fits(m0) || !fits(m1) || !fits(m0 + m1) || !fits(v);
        if (hit && r.ovf_stage == `NN_STAGE_NONE) r.ovf_stage = `NN_STAGE_OUT;
        r.ovf |= hit;
        zhit   = !r.ovf && wrap(v) == '0;
        if (zhit && r.zero_stage == `NN_STAGE_NONE) r.zero_stage = `NN_STAGE_OUT;
        r.zero |= zhit;
        // Output shift, lost bits mean overflow
        v   = longint'(wrap(v)) <<< `NN_POST_SHIFT;
        hit = !fits(v);
        if (hit && r.ovf_stage == `NN_STAGE_NONE) r.ovf_stage = `NN_STAGE_POST;
        r.ovf |= hit;
        zhit   = !r.ovf && wrap(v) == '0;
        if (zhit && r.zero_stage == `NN_STAGE_NONE) r.zero_stage = `NN_STAGE_POST;
        r.zero |= zhit;
        r.data  = r.ovf ? `NN_SAT_VALUE : wrap(v);       // Saturate on any overflow
        return r;
    endfunction

    //==========================================================================
    // Stimulus tasks, inputs change on the falling edge
    //==========================================================================
    task automatic send(input nn_data_t a, input nn_data_t b);
        @(negedge clk);
        enable  = 1'b1;
        input_1 = a;
        input_2 = b;
        exp_q.push_back(model(a, b));
    endtask

    // Enable low, inputs wander and must be ignored
    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            enable  = 1'b0;
            input_1 = $urandom;
            input_2 = $urandom;
        end
    endtask

    function automatic nn_data_t small_word();
        return nn_data_t'($urandom_range(2_000_000)) - 1_000_000;
    endfunction

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);                 // Away from the scoreboard edge
            waited++;
        end
        if (exp_q.size() != 0) begin
            stop_run("Outputs stopped arriving while items were still in flight");
        end
    endtask

    //==========================================================================
    // Checking
    //==========================================================================
    assert property (@(posedge clk) !resetn |-> at_reset_values())
        else stop_run($sformatf("ERR %0t: outputs not at reset values during reset", $time));

    // One strobe per item, four edges after its enable, none in gaps
    assert property (@(posedge clk) disable iff (!resetn) out_valid == $past(enable, 4))
        else stop_run($sformatf("ERR %0t: out_valid %0b off the enable timing", $time,
                                out_valid));

    assert property (@(posedge clk) disable iff (!resetn)
        !out_valid |-> $stable(final_output) && $stable(total_ovf) && $stable(total_zero) &&
                       $stable(ovf_stage) && $stable(zero_stage))
        else stop_run($sformatf("ERR %0t: outputs changed without out_valid", $time));

    always @(negedge clk) begin : scoreboard
        result_t want;
        result_t got;
        if (resetn && out_valid) begin
            if (exp_q.size() == 0) begin
                stop_run("A result came out with no item in flight");
            end else begin
                want = exp_q.pop_front();
                got  = {final_output, total_ovf, total_zero, ovf_stage, zero_stage};
                assert (got == want)
                    else stop_run($sformatf("ERR %0t: got %s, want %s", $time,
                                            result_text(got), result_text(want)));
            end
        end
    end

    //==========================================================================
    // Test sequence
    //==========================================================================
    initial begin
        void'($urandom(32'h4c4));
        resetn  = 1'b1;
        enable  = 1'b0;
        input_1 = '0;
        input_2 = '0;
        #1 resetn = 1'b0;                   // Real falling edge for the async reset
        repeat (10) @(negedge clk);
        resetn = 1'b1;
        idle(3);
        assert (at_reset_values())
            else stop_run($sformatf("ERR %0t: outputs left reset values while idle", $time));

        // Moderate words, negatives keep their sign through both shifts
        send(100, 200);
        send(-100, 37);
        send(-1000, -555);
        send(12345, -67890);
        idle(1);
        drain();

        repeat (20) send(small_word(), small_word());       // Back to back
        idle(1);
        drain();

        // Shifted inputs times the hidden weights always fit one word,
        // so the largest words overflow at the output neuron
        send(32'sh7fff_ffff, 32'sh7fff_ffff);
        send(32'sh8000_0000, 32'sh8000_0000);
        send(32'sh7fff_ffff, 0);
        send(32'sh4000_0000, 4);            // Fits until the output shift
        send(-32'sh4000_0000, -8);
        idle(1);
        drain();

        send(2, 100);                       // Shifts to zero at the input
        send(50, 3);
        send(0, 0);
        send(100, -3);                      // Lane 1 sum cancels to zero
        send(-4, 40);
        idle(1);
        drain();

        send(500, 600);
        idle(6);                            // Outputs must hold here
        send(700, -800);
        idle(1);
        drain();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/nn_top.sv
//==========================================================================
// Accelerator top level, plain ports
// Preprocessing, hidden neuron array and output layer wiring
//==========================================================================
`default_nettype none

`include "nn_cfg.svh"

module nn_top import nn_pkg::*; (
    input  logic      clk,
    input  logic      resetn,               // Async, active low
    input  logic      enable,               // Samples both inputs
    input  nn_data_t  input_1,
    input  nn_data_t  input_2,
    output logic      out_valid,            // Four edges after enable
    output nn_data_t  final_output,
    output logic      total_ovf,
    output logic      total_zero,
    output nn_stage_t ovf_stage,
    output nn_stage_t zero_stage
);

    // Stage links
    nn_lane_if pre_lane [`NN_LANES] ();     // Preprocess to neurons
    nn_lane_if hid_lane [`NN_LANES] ();     // Neurons to output layer

    //==========================================================================
    // Stage 1
    //==========================================================================
    nn_preprocess u_pre (
        .clk     (clk),
        .resetn  (resetn),
        .enable  (enable),
        .input_1 (input_1),
        .input_2 (input_2),
        .lane    (pre_lane)
    );

    //==========================================================================
    // Stage 2, one neuron per lane
    //==========================================================================
    for (genvar i = 0; i < `NN_LANES; i++) begin : g_neuron
        localparam nn_data_t LANE_W = (i == 0) ? `NN_W0 : `NN_W1;
        localparam nn_data_t LANE_B = (i == 0) ? `NN_B0 : `NN_B1;

        nn_neuron #(
            .WEIGHT (LANE_W),
            .BIAS   (LANE_B)
        ) u_neuron (
            .clk    (clk),
            .resetn (resetn),
            .x      (pre_lane[i]),
            .y      (hid_lane[i])
        );
    end

    //==========================================================================
    // Stages 3 and 4
    //==========================================================================
    nn_output_layer u_out (
        .clk          (clk),
        .resetn       (resetn),
        .hid          (hid_lane),
        .out_valid    (out_valid),
        .final_output (final_output),
        .total_ovf    (total_ovf),
        .total_zero   (total_zero),
        .ovf_stage    (ovf_stage),
        .zero_stage   (zero_stage)
    );

endmodule

`default_nettype wire

// File: design/nn_output_layer.sv
//==========================================================================
// Pipeline stages 3 and 4, output neuron and postprocessing
// Lane flag merge, weighted sum with bias, left shift, saturation
//==========================================================================
`default_nettype none

`include "nn_cfg.svh"

module nn_output_layer import nn_pkg::*; (
    input  logic      clk,
    input  logic      resetn,               // Async, active low
    nn_lane_if.dst    hid [`NN_LANES],      // Hidden neuron results
    output logic      out_valid,            // One-cycle result strobe
    output nn_data_t  final_output,
    output logic      total_ovf,
    output logic      total_zero,
    output nn_stage_t ovf_stage,            // First overflow stage
    output nn_stage_t zero_stage            // First zero stage
);

    localparam nn_data_t  WO0        = `NN_WO0;
    localparam nn_data_t  WO1        = `NN_WO1;
    localparam nn_data_t  BO         = `NN_BO;
    localparam nn_shamt_t POST_SHIFT = `NN_POST_SHIFT;

    // Lane fields flattened for looping
    logic      [`NN_LANES-1:0] h_valid;
    logic      [`NN_LANES-1:0] h_ovf;
    logic      [`NN_LANES-1:0] h_zero;
    nn_data_t  h_data       [`NN_LANES];
    nn_stage_t h_ovf_stage  [`NN_LANES];
    nn_stage_t h_zero_stage [`NN_LANES];

    for (genvar l = 0; l < `NN_LANES; l++) begin : g_unpack
        assign h_valid[l]      = hid[l].valid;
        assign h_ovf[l]        = hid[l].ovf;
        assign h_zero[l]       = hid[l].zero;
        assign h_data[l]       = hid[l].data;
        assign h_ovf_stage[l]  = hid[l].ovf_stage;
        assign h_zero_stage[l] = hid[l].zero_stage;
    end

    //==========================================================================
    // Stage 3, flag merge and output neuron
    //==========================================================================
    nn_stage_t m_ovf_stage;     // Lowest overflow code among lanes
    nn_stage_t m_zero_stage;    // Lowest zero code among lanes
    nn_data_t  p0, p1;          // Weighted lane words
    nn_data_t  sum_a, sum_b;    // p0 + p1, then + BO
    logic      o_ovf_now;       // Overflow inside the output neuron
    logic      o_ovf_any;
    logic      o_zero_now;

    always_comb begin
        m_ovf_stage  = `NN_STAGE_NONE;
        m_zero_stage = `NN_STAGE_NONE;
        for (int l = 0; l < `NN_LANES; l++) begin
            if (h_ovf_stage[l] < m_ovf_stage)   m_ovf_stage  = h_ovf_stage[l];
            if (h_zero_stage[l] < m_zero_stage) m_zero_stage = h_zero_stage[l];
        end
        p0         = h_data[0] * WO0;
        p1         = h_data[1] * WO1;
        sum_a      = p0 + p1;
        sum_b      = sum_a + BO;
        o_ovf_now  = nn_mul_ovf(h_data[0], WO0) | nn_mul_ovf(h_data[1], WO1) |
                     nn_add_ovf(p0, p1, sum_a) | nn_add_ovf(sum_a, BO, sum_b);
        o_ovf_any  = (|h_ovf) | o_ovf_now;
        o_zero_now = !o_ovf_any && (sum_b == '0);
    end

    logic      s1_valid;
    logic      s1_ovf;
    logic      s1_zero;
    nn_stage_t s1_ovf_stage;
    nn_stage_t s1_zero_stage;
    nn_data_t  s1_data;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            s1_valid      <= 1'b0;
            s1_ovf        <= 1'b0;
            s1_zero       <= 1'b0;
            s1_ovf_stage  <= `NN_STAGE_NONE;
            s1_zero_stage <= `NN_STAGE_NONE;
        end else begin
            s1_valid      <= &h_valid;           // Lanes move in lockstep
            s1_ovf        <= o_ovf_any;
            s1_zero       <= (|h_zero) | o_zero_now;
            s1_ovf_stage  <= nn_stage_mark(m_ovf_stage, o_ovf_now, `NN_STAGE_OUT);
            s1_zero_stage <= nn_stage_mark(m_zero_stage, o_zero_now, `NN_STAGE_OUT);
        end
    end

    always_ff @(posedge clk) begin
        s1_data <= sum_b;
    end

    //==========================================================================
    // Stage 4, postprocessing shift and result registers
    //==========================================================================
    nn_data_t shifted;          // s1_data <<< POST_SHIFT
    logic     p_ovf_now;        // Bits lost in the shift
    logic     p_ovf_any;
    logic     p_zero_now;

    always_comb begin
        shifted    = s1_data <<< POST_SHIFT;
        p_ovf_now  = ((shifted >>> POST_SHIFT) != s1_data);  // Shift back must match
        p_ovf_any  = s1_ovf | p_ovf_now;
        p_zero_now = !p_ovf_any && (shifted == '0);
    end

    // Outputs move only with a valid item, hold otherwise
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            out_valid    <= 1'b0;
            final_output <= '0;
            total_ovf    <= 1'b0;
            total_zero   <= 1'b0;
            ovf_stage    <= `NN_STAGE_NONE;
            zero_stage   <= `NN_STAGE_NONE;
        end else begin
            out_valid <= s1_valid;
            if (s1_valid) begin
                final_output <= p_ovf_any ? `NN_SAT_VALUE : shifted;  // Saturate
                total_ovf    <= p_ovf_any;
                total_zero   <= s1_zero | p_zero_now;
                ovf_stage    <= nn_stage_mark(s1_ovf_stage, p_ovf_now, `NN_STAGE_POST);
                zero_stage   <= nn_stage_mark(s1_zero_stage, p_zero_now, `NN_STAGE_POST);
            end
        end
    end

endmodule

`default_nettype wire

// File: design/nn_neuron.sv
//==========================================================================
// Pipeline stage 2, one hidden neuron
// Multiply by weight, add bias, overflow and zero checks
//==========================================================================
`default_nettype none

`include "nn_cfg.svh"

module nn_neuron import nn_pkg::*; #(
    parameter nn_data_t WEIGHT = 1,         // Lane weight
    parameter nn_data_t BIAS   = 0          // Lane bias
) (
    input  logic   clk,
    input  logic   resetn,                  // Async, active low
    nn_lane_if.dst x,                       // From preprocessing
    nn_lane_if.src y                        // To output layer
);

    nn_data_t prod;         // Low word of x * WEIGHT
    nn_data_t sum;          // prod + BIAS
    logic     mul_ovf;      // Product needs more than one word
    logic     add_ovf;      // Bias add wrapped
    logic     ovf_now;      // This stage overflowed
    logic     ovf_any;      // Overflow incoming or here
    logic     zero_now;     // Zero sum, valid only without overflow

    //==========================================================================
    // Multiply-accumulate
    //==========================================================================
    always_comb begin
        prod     = x.data * WEIGHT;                  // Wraps, checked below
        sum      = prod + BIAS;
        mul_ovf  = nn_mul_ovf(x.data, WEIGHT);
        add_ovf  = nn_add_ovf(prod, BIAS, sum);
        ovf_now  = mul_ovf | add_ovf;
        ovf_any  = x.ovf | ovf_now;
        zero_now = !ovf_any && (sum == '0);          // No zero check after overflow
    end

    //==========================================================================
    // Stage registers
    //==========================================================================
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            y.valid      <= 1'b0;
            y.ovf        <= 1'b0;
            y.zero       <= 1'b0;
            y.ovf_stage  <= `NN_STAGE_NONE;
            y.zero_stage <= `NN_STAGE_NONE;
        end else begin
            y.valid      <= x.valid;
            y.ovf        <= ovf_any;                 // Sticky for the item
            y.zero       <= x.zero | zero_now;
            y.ovf_stage  <= nn_stage_mark(x.ovf_stage, ovf_now, `NN_STAGE_HID);
            y.zero_stage <= nn_stage_mark(x.zero_stage, zero_now, `NN_STAGE_HID);
        end
    end

    // Result word, wrapped value on overflow, saturated at the end
    always_ff @(posedge clk) begin
        y.data <= sum;
    end

endmodule

`default_nettype wire

// File: design/nn_preprocess.sv
//==========================================================================
// Pipeline stage 1, input preprocessing
// Arithmetic right shift of both inputs, lane flags start here
//==========================================================================
`default_nettype none

`include "nn_cfg.svh"

module nn_preprocess import nn_pkg::*; (
    input  logic     clk,
    input  logic     resetn,                // Async, active low
    input  logic     enable,                // Item strobe
    input  nn_data_t input_1,
    input  nn_data_t input_2,
    nn_lane_if.src   lane [`NN_LANES]       // One lane per hidden neuron
);

    // Per-lane shift amount
    localparam nn_shamt_t PRE_SHIFT [`NN_LANES] = '{`NN_PRE_SHIFT_0, `NN_PRE_SHIFT_1};

    nn_data_t in_word [`NN_LANES];          // Raw inputs by lane
    nn_data_t shifted [`NN_LANES];          // After right shift
    logic     [`NN_LANES-1:0] lane_zero;    // Per-lane zero hit
    logic     any_zero;                     // Shared by all lanes

    assign in_word[0] = input_1;
    assign in_word[1] = input_2;

    // Either input zero marks the whole item
    assign any_zero = |lane_zero;

    //==========================================================================
    // Lane registers
    //==========================================================================
    for (genvar l = 0; l < `NN_LANES; l++) begin : g_lane

        // Sign-keeping shift
        assign shifted[l]   = in_word[l] >>> PRE_SHIFT[l];
        assign lane_zero[l] = (shifted[l] == '0);

        // Control and flags
        always_ff @(posedge clk or negedge resetn) begin
            if (!resetn) begin
                lane[l].valid      <= 1'b0;
                lane[l].ovf        <= 1'b0;
                lane[l].zero       <= 1'b0;
                lane[l].ovf_stage  <= `NN_STAGE_NONE;
                lane[l].zero_stage <= `NN_STAGE_NONE;
            end else begin
                lane[l].valid      <= enable;          // Valid follows the strobe
                lane[l].ovf        <= 1'b0;            // Shift right never overflows
                lane[l].ovf_stage  <= `NN_STAGE_NONE;
                lane[l].zero       <= any_zero;
                lane[l].zero_stage <= any_zero ? `NN_STAGE_PRE : `NN_STAGE_NONE;
            end
        end

        // Payload
        always_ff @(posedge clk) begin
            lane[l].data <= shifted[l];
        end

    end

endmodule

`default_nettype wire

// File: design/nn_lane_if.sv
//==========================================================================
// Lane link between pipeline stages
// One data word with its valid strobe and overflow and zero flags
//==========================================================================
`default_nettype none

`include "nn_cfg.svh"

interface nn_lane_if import nn_pkg::*; ();

    logic      valid;       // Item present this cycle
    nn_data_t  data;        // Lane result word
    logic      ovf;         // Overflow seen so far
    logic      zero;        // Zero result seen so far
    nn_stage_t ovf_stage;   // First overflow stage
    nn_stage_t zero_stage;  // First zero stage

    // Producing stage
    modport src (output valid, output data, output ovf, output zero,
                 output ovf_stage, output zero_stage);

    // Consuming stage, no handshake back
    modport dst (input valid, input data, input ovf, input zero,
                 input ovf_stage, input zero_stage);

endinterface

`default_nettype wire

// File: design/nn_pkg.sv
//==========================================================================
// Shared types of the accelerator datapath
// Overflow and first-stage helper functions
//==========================================================================
`default_nettype none

`include "nn_cfg.svh"

package nn_pkg;

    typedef logic signed [`NN_DATA_W-1:0] nn_data_t;  // Data word
    typedef logic        [2:0]            nn_stage_t; // Stage code
    typedef logic        [4:0]            nn_shamt_t; // Shift amount

    // True if the full signed product a*b does not fit one data word
    function automatic logic nn_mul_ovf(input nn_data_t a, input nn_data_t b);
        logic signed [2*`NN_DATA_W-1:0] p;
        logic        [`NN_DATA_W:0]     upper;
        p     = a * b;                             // Full width product
        upper = p[2*`NN_DATA_W-1:`NN_DATA_W-1];    // Sign bit plus all above
        return !((&upper) || !(|upper));
    endfunction

    // Signed add overflow, both operands same sign and sum flipped
    function automatic logic nn_add_ovf(input nn_data_t a, input nn_data_t b,
                                        input nn_data_t s);
        return (a[`NN_DATA_W-1] == b[`NN_DATA_W-1]) &&
               (s[`NN_DATA_W-1] != a[`NN_DATA_W-1]);
    endfunction

    // Keep the earliest stage, record code only on first hit
    function automatic nn_stage_t nn_stage_mark(input nn_stage_t cur, input logic hit,
                                                input nn_stage_t code);
        return (hit && cur == `NN_STAGE_NONE) ? code : cur;
    endfunction

endpackage

`default_nettype wire

// File: design/nn_cfg.svh
//==========================================================================
// Fixed configuration of the neural network accelerator
// Data width, lane count, weights, biases, shift amounts, stage codes
//==========================================================================
`ifndef NN_CFG_SVH
`define NN_CFG_SVH

//==========================================================================
// Datapath geometry
//==========================================================================
`define NN_DATA_W       32             // Signed data word width
`define NN_LANES        2              // Hidden neurons, one per input

// Preprocessing, arithmetic right shift per input
`define NN_PRE_SHIFT_0  5'd2
`define NN_PRE_SHIFT_1  5'd2

//==========================================================================
// Weights and biases
//==========================================================================
// Hidden neuron on lane 0
`define NN_W0           32'sd3
`define NN_B0           32'sd1

// Hidden neuron on lane 1
`define NN_W1           32'sd2
`define NN_B1           32'sd2

// Output neuron, one weight per hidden lane
`define NN_WO0          32'sd2
`define NN_WO1          32'sd1
`define NN_BO           32'sd3

// Postprocessing, arithmetic left shift of the result
`define NN_POST_SHIFT   5'd1

// Result driven on any overflow
`define NN_SAT_VALUE    32'sh7fff_ffff

//==========================================================================
// Stage codes, ordered by pipeline position
//==========================================================================
`define NN_STAGE_PRE    3'd1           // Input shift
`define NN_STAGE_HID    3'd2           // Hidden neurons
`define NN_STAGE_OUT    3'd3           // Output neuron
`define NN_STAGE_POST   3'd4           // Output shift
`define NN_STAGE_NONE   3'd7           // Nothing seen yet

`endif
